// ==== source/eth_traffic_pkg.sv ====
// Ethernet traffic generator definitions

package eth_traffic_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int NUM_CHANNEL   = 4;
    localparam int NUM_PAIR      = NUM_CHANNEL / 2;

    localparam int DATA_W        = 64;
    localparam int CSR_DATA_W    = 32;
    localparam int CSR_ADDR_W    = 8;

    // Address fields: pair, channel, register
    localparam int PAIR_SEL_W    = 4;
    localparam int REG_SEL_W     = 3;

    // Heartbeat divisor, sized for simulation
    localparam int HEARTBEAT_DIV = 125;
    localparam int HB_CNT_W      = $clog2(HEARTBEAT_DIV);

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [DATA_W-1:0]     data_word_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [15:0]           pkt_len_t;

    // Register offsets within one channel
    typedef enum logic [REG_SEL_W-1:0] {
        REG_CTRL      = 3'd0,
        REG_PKT_COUNT = 3'd1,
        REG_PKT_LEN   = 3'd2,
        REG_SEED      = 3'd3,
        REG_TX_COUNT  = 3'd4,
        REG_RX_GOOD   = 3'd5,
        REG_RX_BAD    = 3'd6
    } csr_reg_e;

    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1
    } gen_state_e;

endpackage

// ==== source/csr_address_decoder.sv ====
// CSR address decoder

`timescale 1ns/1ps

module csr_address_decoder (
    input  logic                                             clk_125,
    input  logic                                             rst_n,

    input  logic                                             csr_valid,
    input  logic                                             csr_write,
    input  eth_traffic_pkg::csr_addr_t                       csr_address,
    input  eth_traffic_pkg::csr_data_t                       csr_writedata,
    output logic                                             csr_ready,
    output logic                                             csr_rdata_valid,
    output eth_traffic_pkg::csr_data_t                       csr_readdata,

    output logic [eth_traffic_pkg::NUM_PAIR-1:0]             reg_wr,
    output logic [eth_traffic_pkg::NUM_PAIR-1:0]             reg_rd,
    output eth_traffic_pkg::csr_reg_e                        reg_sel,
    output logic                                             reg_channel,
    output eth_traffic_pkg::csr_data_t                       reg_wdata,
    input  eth_traffic_pkg::csr_data_t [eth_traffic_pkg::NUM_PAIR-1:0] reg_rdata
);

    import eth_traffic_pkg::*;

    logic                  accept;
    logic [PAIR_SEL_W-1:0] req_pair;
    logic                  req_channel;
    logic [REG_SEL_W-1:0]  req_reg;

    logic [PAIR_SEL_W-1:0] rd_pair_q;
    logic [1:0]            rd_pipe;
    csr_data_t             rd_mux;

    assign accept      = csr_valid && csr_ready;
    assign req_pair    = csr_address[CSR_ADDR_W-1 -: PAIR_SEL_W];
    assign req_channel = csr_address[REG_SEL_W];
    assign req_reg     = csr_address[REG_SEL_W-1:0];

    // Empty pair windows fall through to zero
    always_comb begin
        rd_mux = '0;
        for (int p = 0; p < NUM_PAIR; p++) begin
            if (rd_pair_q == PAIR_SEL_W'(p)) begin
                rd_mux = reg_rdata[p];
            end
        end
    end

    always_ff @(posedge clk_125 or negedge rst_n) begin
        if (!rst_n) begin
            csr_ready       <= 1'b1;
            csr_rdata_valid <= 1'b0;
            csr_readdata    <= '0;
            reg_wr          <= '0;
            reg_rd          <= '0;
            reg_sel         <= REG_CTRL;
            reg_channel     <= 1'b0;
            reg_wdata       <= '0;
            rd_pair_q       <= '0;
            rd_pipe         <= '0;
        end else begin
            reg_wr          <= '0;
            reg_rd          <= '0;
            rd_pipe         <= {rd_pipe[0], accept && !csr_write};
            csr_rdata_valid <= rd_pipe[1];

            // Read data is back from the pair, present it
            if (rd_pipe[1]) begin
                csr_readdata <= rd_mux;
                csr_ready    <= 1'b1;
            end

            if (accept) begin
                reg_sel     <= csr_reg_e'(req_reg);
                reg_channel <= req_channel;
                reg_wdata   <= csr_writedata;
                if (!csr_write) begin
                    csr_ready <= 1'b0;
                    rd_pair_q <= req_pair;
                end
                for (int p = 0; p < NUM_PAIR; p++) begin
                    if (req_pair == PAIR_SEL_W'(p)) begin
                        reg_wr[p] <= csr_write;
                        reg_rd[p] <= !csr_write;
                    end
                end
            end
        end
    end

endmodule

// ==== source/packet_generator.sv ====
// Patterned packet generator

`timescale 1ns/1ps

module packet_generator (
    input  logic                        clk_125,
    input  logic                        rst_n,

    input  logic                        start,
    input  eth_traffic_pkg::csr_data_t  pkt_count,
    input  eth_traffic_pkg::pkt_len_t   pkt_len,
    input  eth_traffic_pkg::csr_data_t  seed,

    input  logic                        tx_ready,
    output logic                        tx_valid,
    output logic                        tx_sop,
    output logic                        tx_eop,
    output eth_traffic_pkg::data_word_t tx_data,

    output eth_traffic_pkg::csr_data_t  tx_sent
);

    import eth_traffic_pkg::*;

    gen_state_e state;

    // Run parameters captured at start
    csr_data_t  count_q;
    pkt_len_t   len_q;
    csr_data_t  seed_q;

    // Position in packet and running index of the word on the bus
    pkt_len_t   pos;
    csr_data_t  word_idx;
    logic       last_word;

    // A zero length behaves like one
    assign last_word = (pos + 16'd1) >= len_q;

    assign tx_valid = (state == SEND);
    assign tx_sop   = (pos == '0);
    assign tx_eop   = last_word;
    assign tx_data  = {seed_q, word_idx};

    always_ff @(posedge clk_125 or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            count_q  <= '0;
            len_q    <= '0;
            seed_q   <= '0;
            pos      <= '0;
            word_idx <= '0;
            tx_sent  <= '0;
        end else if (start) begin
            // Restart from the first word, also mid run
            state    <= (pkt_count != '0) ? SEND : IDLE;
            count_q  <= pkt_count;
            len_q    <= pkt_len;
            seed_q   <= seed;
            pos      <= '0;
            word_idx <= '0;
            tx_sent  <= '0;
        end else begin
            case (state)
                SEND: begin
                    if (tx_ready) begin
                        word_idx <= word_idx + 32'd1;
                        if (last_word) begin
                            pos     <= '0;
                            tx_sent <= tx_sent + 32'd1;
                            if (tx_sent + 32'd1 == count_q) begin
                                state <= IDLE;
                            end
                        end else begin
                            pos <= pos + 16'd1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== source/packet_monitor.sv ====
// Received packet checker

`timescale 1ns/1ps

module packet_monitor (
    input  logic                        clk_125,
    input  logic                        rst_n,

    input  logic                        start,
    input  eth_traffic_pkg::pkt_len_t   pkt_len,
    input  eth_traffic_pkg::csr_data_t  seed,

    input  logic                        rx_valid,
    input  logic                        rx_sop,
    input  logic                        rx_eop,
    input  eth_traffic_pkg::data_word_t rx_data,

    output eth_traffic_pkg::csr_data_t  rx_good,
    output eth_traffic_pkg::csr_data_t  rx_bad
);

    import eth_traffic_pkg::*;

    pkt_len_t   len_q;
    csr_data_t  seed_q;

    csr_data_t  exp_idx;
    pkt_len_t   pos;
    logic       bad_acc;
    logic       hunt;

    data_word_t exp_word;
    logic       last_word;
    logic       word_err;

    assign exp_word  = {seed_q, exp_idx};
    assign last_word = (pos + 16'd1) >= len_q;

    // Wrong data, sop off position 0, eop off the last position
    assign word_err = (rx_data != exp_word)
                   || (rx_sop != (pos == '0))
                   || (rx_eop != last_word);

    always_ff @(posedge clk_125 or negedge rst_n) begin
        if (!rst_n) begin
            len_q   <= '0;
            seed_q  <= '0;
            exp_idx <= '0;
            pos     <= '0;
            bad_acc <= 1'b0;
            hunt    <= 1'b0;
            rx_good <= '0;
            rx_bad  <= '0;
        end else if (start) begin
            len_q   <= pkt_len;
            seed_q  <= seed;
            exp_idx <= '0;
            pos     <= '0;
            bad_acc <= 1'b0;
            hunt    <= 1'b0;
            rx_good <= '0;
            rx_bad  <= '0;
        end else if (rx_valid) begin
            // Index advances on every word, in sync or not
            exp_idx <= exp_idx + 32'd1;

            // Skip words until a sop after a bad packet
            if (!hunt || rx_sop) begin
                hunt <= 1'b0;
                if (rx_eop) begin
                    pos     <= '0;
                    bad_acc <= 1'b0;
                    if (bad_acc || word_err) begin
                        rx_bad <= rx_bad + 32'd1;
                        hunt   <= 1'b1;
                    end else begin
                        rx_good <= rx_good + 32'd1;
                    end
                end else begin
                    pos     <= pos + 16'd1;
                    bad_acc <= bad_acc || word_err;
                end
            end
        end
    end

endmodule

// ==== source/traffic_controller_pair.sv ====
// Traffic controller for one channel pair

`timescale 1ns/1ps

module traffic_controller_pair (
    input  logic                             clk_125,
    input  logic                             rst_n,

    input  logic                             reg_wr,
    input  logic                             reg_rd,
    input  eth_traffic_pkg::csr_reg_e        reg_sel,
    input  logic                             reg_channel,
    input  eth_traffic_pkg::csr_data_t       reg_wdata,
    output eth_traffic_pkg::csr_data_t       reg_rdata,

    output logic [1:0]                       tx_valid,
    output logic [1:0]                       tx_sop,
    output logic [1:0]                       tx_eop,
    output eth_traffic_pkg::data_word_t [1:0] tx_data,
    input  logic [1:0]                       tx_ready,

    input  logic [1:0]                       rx_valid,
    input  logic [1:0]                       rx_sop,
    input  logic [1:0]                       rx_eop,
    input  eth_traffic_pkg::data_word_t [1:0] rx_data
);

    import eth_traffic_pkg::*;

    csr_data_t [1:0] pkt_count_q;
    pkt_len_t  [1:0] pkt_len_q;
    csr_data_t [1:0] seed_q;
    logic      [1:0] start_q;

    csr_data_t [1:0] tx_sent;
    csr_data_t [1:0] rx_good;
    csr_data_t [1:0] rx_bad;

    // ----------------------------------------
    // Register writes and readback
    // ----------------------------------------
    always_ff @(posedge clk_125 or negedge rst_n) begin
        if (!rst_n) begin
            pkt_count_q <= '0;
            pkt_len_q   <= '0;
            seed_q      <= '0;
            start_q     <= '0;
            reg_rdata   <= '0;
        end else begin
            start_q <= '0;

            if (reg_wr) begin
                case (reg_sel)
                    REG_CTRL:      start_q[reg_channel]     <= reg_wdata[0];
                    REG_PKT_COUNT: pkt_count_q[reg_channel] <= reg_wdata;
                    REG_PKT_LEN:   pkt_len_q[reg_channel]   <= reg_wdata[15:0];
                    REG_SEED:      seed_q[reg_channel]      <= reg_wdata;
                    default:       ;
                endcase
            end

            if (reg_rd) begin
                case (reg_sel)
                    REG_PKT_COUNT: reg_rdata <= pkt_count_q[reg_channel];
                    REG_PKT_LEN:   reg_rdata <= csr_data_t'(pkt_len_q[reg_channel]);
                    REG_SEED:      reg_rdata <= seed_q[reg_channel];
                    REG_TX_COUNT:  reg_rdata <= tx_sent[reg_channel];
                    REG_RX_GOOD:   reg_rdata <= rx_good[reg_channel];
                    REG_RX_BAD:    reg_rdata <= rx_bad[reg_channel];
                    default:       reg_rdata <= '0;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Per channel datapath
    // ----------------------------------------
    for (genvar ch = 0; ch < 2; ch++) begin : g_chan
        packet_generator u_gen (
            .clk_125   (clk_125),
            .rst_n     (rst_n),
            .start     (start_q[ch]),
            .pkt_count (pkt_count_q[ch]),
            .pkt_len   (pkt_len_q[ch]),
            .seed      (seed_q[ch]),
            .tx_ready  (tx_ready[ch]),
            .tx_valid  (tx_valid[ch]),
            .tx_sop    (tx_sop[ch]),
            .tx_eop    (tx_eop[ch]),
            .tx_data   (tx_data[ch]),
            .tx_sent   (tx_sent[ch])
        );

        packet_monitor u_mon (
            .clk_125  (clk_125),
            .rst_n    (rst_n),
            .start    (start_q[ch]),
            .pkt_len  (pkt_len_q[ch]),
            .seed     (seed_q[ch]),
            .rx_valid (rx_valid[ch]),
            .rx_sop   (rx_sop[ch]),
            .rx_eop   (rx_eop[ch]),
            .rx_data  (rx_data[ch]),
            .rx_good  (rx_good[ch]),
            .rx_bad   (rx_bad[ch])
        );
    end

endmodule

// ==== source/eth_traffic_top.sv ====
// Ethernet traffic generator top level

`timescale 1ns/1ps

module eth_traffic_top (
    input  logic                                                     clk_125,
    input  logic                                                     rst_n,

    // CSR port
    input  logic                                                     csr_valid,
    input  logic                                                     csr_write,
    input  eth_traffic_pkg::csr_addr_t                               csr_address,
    input  eth_traffic_pkg::csr_data_t                               csr_writedata,
    output logic                                                     csr_ready,
    output logic                                                     csr_rdata_valid,
    output eth_traffic_pkg::csr_data_t                               csr_readdata,

    // Transmit streams
    output logic [eth_traffic_pkg::NUM_CHANNEL-1:0]                  tx_valid,
    output logic [eth_traffic_pkg::NUM_CHANNEL-1:0]                  tx_sop,
    output logic [eth_traffic_pkg::NUM_CHANNEL-1:0]                  tx_eop,
    output eth_traffic_pkg::data_word_t [eth_traffic_pkg::NUM_CHANNEL-1:0] tx_data,
    input  logic [eth_traffic_pkg::NUM_CHANNEL-1:0]                  tx_ready,

    // Receive streams
    input  logic [eth_traffic_pkg::NUM_CHANNEL-1:0]                  rx_valid,
    input  logic [eth_traffic_pkg::NUM_CHANNEL-1:0]                  rx_sop,
    input  logic [eth_traffic_pkg::NUM_CHANNEL-1:0]                  rx_eop,
    input  eth_traffic_pkg::data_word_t [eth_traffic_pkg::NUM_CHANNEL-1:0] rx_data,

    output logic                                                     led_heartbeat
);

    import eth_traffic_pkg::*;

    logic [NUM_PAIR-1:0]      reg_wr;
    logic [NUM_PAIR-1:0]      reg_rd;
    csr_reg_e                 reg_sel;
    logic                     reg_channel;
    csr_data_t                reg_wdata;
    csr_data_t [NUM_PAIR-1:0] reg_rdata;

    logic [HB_CNT_W-1:0]      hb_cnt;

    // ----------------------------------------
    // Heartbeat
    // ----------------------------------------
    always_ff @(posedge clk_125 or negedge rst_n) begin
        if (!rst_n) begin
            hb_cnt        <= '0;
            led_heartbeat <= 1'b0;
        end else if (hb_cnt == HB_CNT_W'(HEARTBEAT_DIV - 1)) begin
            hb_cnt        <= '0;
            led_heartbeat <= ~led_heartbeat;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // CSR decode
    // ----------------------------------------
    csr_address_decoder u_decoder (
        .clk_125         (clk_125),
        .rst_n           (rst_n),
        .csr_valid       (csr_valid),
        .csr_write       (csr_write),
        .csr_address     (csr_address),
        .csr_writedata   (csr_writedata),
        .csr_ready       (csr_ready),
        .csr_rdata_valid (csr_rdata_valid),
        .csr_readdata    (csr_readdata),
        .reg_wr          (reg_wr),
        .reg_rd          (reg_rd),
        .reg_sel         (reg_sel),
        .reg_channel     (reg_channel),
        .reg_wdata       (reg_wdata),
        .reg_rdata       (reg_rdata)
    );

    // Channels 2p and 2p+1 share pair p
    for (genvar p = 0; p < NUM_PAIR; p++) begin : g_pair
        traffic_controller_pair u_pair (
            .clk_125     (clk_125),
            .rst_n       (rst_n),
            .reg_wr      (reg_wr[p]),
            .reg_rd      (reg_rd[p]),
            .reg_sel     (reg_sel),
            .reg_channel (reg_channel),
            .reg_wdata   (reg_wdata),
            .reg_rdata   (reg_rdata[p]),
            .tx_valid    (tx_valid[2*p+1:2*p]),
            .tx_sop      (tx_sop[2*p+1:2*p]),
            .tx_eop      (tx_eop[2*p+1:2*p]),
            .tx_data     (tx_data[2*p+1:2*p]),
            .tx_ready    (tx_ready[2*p+1:2*p]),
            .rx_valid    (rx_valid[2*p+1:2*p]),
            .rx_sop      (rx_sop[2*p+1:2*p]),
            .rx_eop      (rx_eop[2*p+1:2*p]),
            .rx_data     (rx_data[2*p+1:2*p])
        );
    end

endmodule

// ==== verification/eth_traffic_tb.sv ====
// Ethernet traffic generator testbench

`timescale 1ns/1ps

module eth_traffic_tb;

    import eth_traffic_pkg::*;

    // ----------------------------------------
    // Channel programming
    // ----------------------------------------
    localparam int        CFG_COUNT [NUM_CHANNEL] = '{5, 7, 3, 4};
    localparam int        CFG_LEN   [NUM_CHANNEL] = '{4, 1, 9, 6};
    localparam csr_data_t CFG_SEED  [NUM_CHANNEL] = '{32'hA5A5_0001, 32'h5A5A_0002,
                                                      32'h1234_0003, 32'hC0DE_0004};

    localparam int TOTAL_WORDS = CFG_COUNT[0] * CFG_LEN[0] + CFG_COUNT[1] * CFG_LEN[1]
                               + CFG_COUNT[2] * CFG_LEN[2] + CFG_COUNT[3] * CFG_LEN[3];
    // Two runs at worst a quarter rate, CSR traffic and three heartbeat periods
    localparam int TIMEOUT_CYCLES = 2 * 4 * TOTAL_WORDS + 3 * HEARTBEAT_DIV + 1000;

    // Word hit by the corrupting loopback
    localparam int BAD_CH  = 2;
    localparam int BAD_IDX = 10;

    logic                               clk_125;
    logic                               rst_n;
    logic                               csr_valid;
    logic                               csr_write;
    csr_addr_t                          csr_address;
    csr_data_t                          csr_writedata;
    logic                               csr_ready;
    logic                               csr_rdata_valid;
    csr_data_t                          csr_readdata;
    logic [NUM_CHANNEL-1:0]             tx_valid;
    logic [NUM_CHANNEL-1:0]             tx_sop;
    logic [NUM_CHANNEL-1:0]             tx_eop;
    data_word_t [NUM_CHANNEL-1:0]       tx_data;
    logic [NUM_CHANNEL-1:0]             tx_ready = '0;
    logic [NUM_CHANNEL-1:0]             rx_valid = '0;
    logic [NUM_CHANNEL-1:0]             rx_sop   = '0;
    logic [NUM_CHANNEL-1:0]             rx_eop   = '0;
    data_word_t [NUM_CHANNEL-1:0]       rx_data  = '0;
    logic                               led_heartbeat;

    logic [15:0]  lfsr_state = 16'd47;
    int unsigned  cyc        = 0;
    int unsigned  tx_idx   [NUM_CHANNEL];
    int unsigned  lb_delay [NUM_CHANNEL];
    // Loopback entry is {due cycle, sop, eop, data}
    logic [97:0]  lb_q     [NUM_CHANNEL][$];
    logic         corrupt_en = 1'b0;

    int unsigned  hb_edges   = 0;
    int unsigned  hb_last    = 1;
    int unsigned  hb_toggles = 0;
    logic         led_prev   = 1'b0;

    eth_traffic_top eth_traffic_top_i (.*);

    always #4 clk_125 = ~clk_125;

    // ----------------------------------------
    // Reference, random numbers, checks
    // ----------------------------------------
    function automatic data_word_t expected_word(input csr_data_t seed, input int unsigned index);
        return {seed, csr_data_t'(index)};
    endfunction

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int unsigned rand_bits(input int n);
        int unsigned value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic csr_addr_t reg_addr(input int pair, input int chan, input csr_reg_e r);
        logic [PAIR_SEL_W-1:0] pair_f;
        pair_f = pair[PAIR_SEL_W-1:0];
        return {pair_f, chan[0], r};
    endfunction

    task automatic end_in_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input data_word_t expected, input data_word_t actual,
                              input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, expected %h, got %h", $time, what, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_csr(input csr_data_t expected, input csr_data_t actual,
                             input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, expected %0d, got %0d", $time, what, expected, actual);
            end_in_failure();
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, expected %b, got %b", $time, what, expected, actual);
            end_in_failure();
        end
    endtask

    // ----------------------------------------
    // CSR access, called on a falling edge
    // ----------------------------------------
    task automatic csr_write_reg(input csr_addr_t addr, input csr_data_t data);
        csr_valid     = 1'b1;
        csr_write     = 1'b1;
        csr_address   = addr;
        csr_writedata = data;
        while (!csr_ready) @(negedge clk_125);
        @(negedge clk_125);
        csr_valid = 1'b0;
    endtask

    task automatic csr_read_reg(input csr_addr_t addr, output csr_data_t data);
        csr_valid   = 1'b1;
        csr_write   = 1'b0;
        csr_address = addr;
        while (!csr_ready) @(negedge clk_125);
        @(negedge clk_125);
        csr_valid = 1'b0;
        while (!csr_rdata_valid) @(negedge clk_125);
        data = csr_readdata;
    endtask

    task automatic expect_reg(input csr_addr_t addr, input csr_data_t expected,
                              input string what);
        csr_data_t data;
        csr_read_reg(addr, data);
        check_csr(expected, data, what);
    endtask

    task automatic expect_config();
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            expect_reg(reg_addr(ch / 2, ch % 2, REG_PKT_COUNT), CFG_COUNT[ch],
                       $sformatf("ch%0d PKT_COUNT", ch));
            expect_reg(reg_addr(ch / 2, ch % 2, REG_PKT_LEN), CFG_LEN[ch],
                       $sformatf("ch%0d PKT_LEN", ch));
            expect_reg(reg_addr(ch / 2, ch % 2, REG_SEED), CFG_SEED[ch],
                       $sformatf("ch%0d SEED", ch));
        end
    endtask

    task automatic expect_status(input int ch, input int sent, input int good, input int bad);
        expect_reg(reg_addr(ch / 2, ch % 2, REG_TX_COUNT), sent, $sformatf("ch%0d TX_COUNT", ch));
        expect_reg(reg_addr(ch / 2, ch % 2, REG_RX_GOOD), good, $sformatf("ch%0d RX_GOOD", ch));
        expect_reg(reg_addr(ch / 2, ch % 2, REG_RX_BAD), bad, $sformatf("ch%0d RX_BAD", ch));
    endtask

    task automatic start_channels();
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            tx_idx[ch] = 0;
        end
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            csr_write_reg(reg_addr(ch / 2, ch % 2, REG_CTRL), 32'd1);
        end
    endtask

    function automatic logic traffic_drained();
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            if (tx_idx[ch] != CFG_COUNT[ch] * CFG_LEN[ch] || lb_q[ch].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_for_traffic();
        while (!traffic_drained()) @(negedge clk_125);
        // Let the last looped word reach the monitor
        repeat (4) @(negedge clk_125);
    endtask

    // ----------------------------------------
    // Transmit check, loopback capture, heartbeat, watchdog
    // ----------------------------------------
    always @(posedge clk_125) begin
        int unsigned pos;
        data_word_t  word;

        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_in_failure();
        end
        if (rst_n) begin
            hb_edges = hb_edges + 1;
            if (led_heartbeat !== led_prev) begin
                check_csr(csr_data_t'(HEARTBEAT_DIV), csr_data_t'(hb_edges - hb_last),
                          "heartbeat toggle interval");
                hb_last    = hb_edges;
                hb_toggles = hb_toggles + 1;
            end
            led_prev = led_heartbeat;

            for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
                if (tx_valid[ch] && tx_ready[ch]) begin
                    if (tx_idx[ch] >= CFG_COUNT[ch] * CFG_LEN[ch]) begin
                        $display("Channel %0d sent more words than programmed", ch);
                        end_in_failure();
                    end
                    pos = tx_idx[ch] % CFG_LEN[ch];
                    check_word(expected_word(CFG_SEED[ch], tx_idx[ch]), tx_data[ch],
                               $sformatf("ch%0d tx word %0d", ch, tx_idx[ch]));
                    check_flag(pos == 0, tx_sop[ch], $sformatf("ch%0d tx_sop", ch));
                    check_flag(pos == CFG_LEN[ch] - 1, tx_eop[ch], $sformatf("ch%0d tx_eop", ch));
                    word = tx_data[ch];
                    if (corrupt_en && ch == BAD_CH && tx_idx[ch] == BAD_IDX) begin
                        word[0] = ~word[0];
                    end
                    lb_q[ch].push_back({32'(cyc + lb_delay[ch]), tx_sop[ch], tx_eop[ch], word});
                    tx_idx[ch] = tx_idx[ch] + 1;
                end
            end
        end
    end

    // Stalls, loopback delay and receive drive
    always @(negedge clk_125) begin
        logic [97:0] entry;

        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            // Ready three cycles in four on average
            tx_ready[ch] = (rand_bits(2) != 0);
            lb_delay[ch] = rand_bits(2);
            rx_valid[ch] = 1'b0;
            rx_sop[ch]   = 1'b0;
            rx_eop[ch]   = 1'b0;
            rx_data[ch]  = '0;
            if (lb_q[ch].size() > 0) begin
                entry = lb_q[ch][0];
                if (entry[97:66] <= cyc) begin
                    entry        = lb_q[ch].pop_front();
                    rx_valid[ch] = 1'b1;
                    rx_sop[ch]   = entry[65];
                    rx_eop[ch]   = entry[64];
                    rx_data[ch]  = entry[63:0];
                end
            end
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        clk_125       = 1'b0;
        rst_n         = 1'b0;
        csr_valid     = 1'b0;
        csr_write     = 1'b0;
        csr_address   = '0;
        csr_writedata = '0;
        repeat (10) @(negedge clk_125);
        rst_n = 1'b1;

        check_flag(1'b0, led_heartbeat, "led_heartbeat after reset");
        check_flag(1'b1, csr_ready, "csr_ready after reset");
        check_flag(1'b0, csr_rdata_valid, "csr_rdata_valid after reset");
        check_flag(1'b0, |tx_valid, "tx_valid after reset");

        // Program and read back, status still zero
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            csr_write_reg(reg_addr(ch / 2, ch % 2, REG_PKT_COUNT), CFG_COUNT[ch]);
            csr_write_reg(reg_addr(ch / 2, ch % 2, REG_PKT_LEN), CFG_LEN[ch]);
            csr_write_reg(reg_addr(ch / 2, ch % 2, REG_SEED), CFG_SEED[ch]);
        end
        expect_config();
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            expect_status(ch, 0, 0, 0);
        end
        expect_reg(reg_addr(0, 1, csr_reg_e'(3'd7)), 32'd0, "unused offset");

        // Empty pair windows
        csr_write_reg(reg_addr(NUM_PAIR, 0, REG_SEED), 32'hDEAD_BEEF);
        csr_write_reg(reg_addr(15, 1, REG_PKT_COUNT), 32'h0000_0077);
        expect_reg(reg_addr(NUM_PAIR, 0, REG_SEED), 32'd0, "empty window seed");
        expect_reg(reg_addr(15, 1, REG_PKT_COUNT), 32'd0, "empty window count");
        expect_config();

        // Clean loopback run
        start_channels();
        wait_for_traffic();
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            expect_status(ch, CFG_COUNT[ch], CFG_COUNT[ch], 0);
        end
        // Control was just written with a one
        expect_reg(reg_addr(0, 0, REG_CTRL), 32'd0, "REG_CTRL readback");

        // Run with one corrupted word
        corrupt_en = 1'b1;
        start_channels();
        wait_for_traffic();
        for (int ch = 0; ch < NUM_CHANNEL; ch++) begin
            if (ch == BAD_CH) begin
                expect_status(ch, CFG_COUNT[ch], CFG_COUNT[ch] - 1, 1);
            end else begin
                expect_status(ch, CFG_COUNT[ch], CFG_COUNT[ch], 0);
            end
        end

        // Several heartbeat periods checked by the edge process
        while (hb_toggles < 3) @(negedge clk_125);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
source/eth_traffic_pkg.sv
source/csr_address_decoder.sv
source/packet_generator.sv
source/packet_monitor.sv
source/traffic_controller_pair.sv
source/eth_traffic_top.sv
verification/eth_traffic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_eth_traffic

verilator --binary -Wno-fatal --top-module eth_traffic_tb -f sources.f -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
